// File: common/commit_pkg.sv
// commit monitor shared definitions
// widths, port and counter counts, counter slots and the
// controller state encoding used across the commit-side blocks

`default_nettype none

package commit_pkg;

  // ------------------------------------------------
  // datapath widths and counts
  // ------------------------------------------------
  // virtual address width of a retired pc
  localparam int unsigned VLEN            = 39;
  localparam int unsigned NR_COMMIT_PORTS = 2;

  // counter bank geometry
  localparam int unsigned PERF_CNT_WIDTH  = 64;
  localparam int unsigned PERF_ADDR_WIDTH = 3;
  localparam int unsigned NR_PERF_CNT     = 5;

  // ------------------------------------------------
  // counter slots
  // ------------------------------------------------
  localparam logic [PERF_ADDR_WIDTH-1:0] PERF_CYCLE       = 3'd0;
  localparam logic [PERF_ADDR_WIDTH-1:0] PERF_INSTRET     = 3'd1;
  localparam logic [PERF_ADDR_WIDTH-1:0] PERF_EXCEPTION   = 3'd2;
  localparam logic [PERF_ADDR_WIDTH-1:0] PERF_MISPREDICT  = 3'd3;
  localparam logic [PERF_ADDR_WIDTH-1:0] PERF_FENCE_STALL = 3'd4;

  // default entries per trace queue
  localparam int unsigned TRACE_DEPTH = 4;

  // ------------------------------------------------
  // flush controller states
  // ------------------------------------------------
  typedef enum logic [0:0] {
    // no flush in flight
    CTRL_IDLE       = 1'b0,
    // fence issued, waiting on the data cache
    CTRL_WAIT_FLUSH = 1'b1
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/commit_ctrl.sv
// commit flush controller
// turns exceptions, eret, fence.i and fence into registered flush pulses
// and holds the data cache flush and the halt for the length of a fence

`timescale 1ns/100ps
`default_nettype none

module commit_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ex_valid_i,
  input  logic eret_i,
  input  logic fence_i_i,
  input  logic fence_i,
  input  logic dcache_flush_ack_i,
  output logic flush_pipeline_o,
  output logic set_pc_o,
  output logic flush_icache_o,
  output logic flush_dcache_o,
  output logic halt_o
);

  commit_pkg::ctrl_state_t state_d, state_q;

  logic flush_pipeline_d, flush_pipeline_q;
  logic set_pc_d, set_pc_q;
  logic flush_icache_d, flush_icache_q;
  logic halt_d, halt_q;

  // ------------------------------------------------
  // next state and pulse decode
  // ------------------------------------------------
  always_comb begin
    state_d          = state_q;
    flush_pipeline_d = 1'b0;
    flush_icache_d   = 1'b0;

    unique case (state_q)
      commit_pkg::CTRL_IDLE: begin
        // any of these restarts fetch from a new pc
        if (ex_valid_i || eret_i || fence_i_i) begin
          flush_pipeline_d = 1'b1;
        end
        if (fence_i_i) begin
          flush_icache_d = 1'b1;
        end
        if (fence_i) begin
          state_d = commit_pkg::CTRL_WAIT_FLUSH;
        end
      end
      commit_pkg::CTRL_WAIT_FLUSH: begin
        // an exception still redirects, the fence keeps waiting
        if (ex_valid_i) begin
          flush_pipeline_d = 1'b1;
        end
        // cache done, release the halt and restart
        if (dcache_flush_ack_i) begin
          state_d          = commit_pkg::CTRL_IDLE;
          flush_pipeline_d = 1'b1;
        end
      end
      default: begin
        state_d = commit_pkg::CTRL_IDLE;
      end
    endcase

    set_pc_d = flush_pipeline_d;
    halt_d   = (state_d == commit_pkg::CTRL_WAIT_FLUSH);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= commit_pkg::CTRL_IDLE;
      flush_pipeline_q <= 1'b0;
      set_pc_q         <= 1'b0;
      flush_icache_q   <= 1'b0;
      halt_q           <= 1'b0;
    end else begin
      state_q          <= state_d;
      flush_pipeline_q <= flush_pipeline_d;
      set_pc_q         <= set_pc_d;
      flush_icache_q   <= flush_icache_d;
      halt_q           <= halt_d;
    end
  end

  assign flush_pipeline_o = flush_pipeline_q;
  assign set_pc_o         = set_pc_q;
  assign flush_icache_o   = flush_icache_q;
  // dcache flush request is high for the whole wait state
  assign flush_dcache_o   = (state_q == commit_pkg::CTRL_WAIT_FLUSH);
  assign halt_o           = halt_q;

endmodule

`default_nettype wire

// File: src/perf_counters.sv
// performance counter bank
// counts cycles, retirements, exceptions, mispredicts and fence stalls,
// with register-style read and write access from software

`timescale 1ns/100ps
`default_nettype none

module perf_counters #(
  parameter int unsigned Width = 64
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     debug_mode_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]   commit_ack_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]   commit_ex_valid_i,
  input  logic                                     branch_valid_i,
  input  logic                                     mispredict_i,
  input  logic                                     halt_i,
  input  logic [commit_pkg::PERF_ADDR_WIDTH-1:0]   perf_addr_i,
  input  logic                                     perf_we_i,
  input  logic [Width-1:0]                         perf_wdata_i,
  output logic [Width-1:0]                         perf_rdata_o
);

  localparam int unsigned EvW = $clog2(commit_pkg::NR_COMMIT_PORTS + 1);

  logic [Width-1:0] cnt_d [commit_pkg::NR_PERF_CNT];
  logic [Width-1:0] cnt_q [commit_pkg::NR_PERF_CNT];
  logic [EvW-1:0]   retire_cnt;
  logic [EvW-1:0]   ex_cnt;
  logic             addr_ok;

  assign addr_ok = (perf_addr_i < commit_pkg::NR_PERF_CNT);

  // per-cycle event counts across the commit ports
  always_comb begin
    retire_cnt = '0;
    ex_cnt     = '0;
    for (int unsigned i = 0; i < commit_pkg::NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i] && !commit_ex_valid_i[i]) begin
        retire_cnt = retire_cnt + 1'b1;
      end
      if (commit_ack_i[i] && commit_ex_valid_i[i]) begin
        ex_cnt = ex_cnt + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // increment, then software write on top
  // ------------------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    // frozen while the hart is halted in debug
    if (!debug_mode_i) begin
      cnt_d[commit_pkg::PERF_CYCLE]     = cnt_q[commit_pkg::PERF_CYCLE] + 1'b1;
      cnt_d[commit_pkg::PERF_INSTRET]   = cnt_q[commit_pkg::PERF_INSTRET] + Width'(retire_cnt);
      cnt_d[commit_pkg::PERF_EXCEPTION] = cnt_q[commit_pkg::PERF_EXCEPTION] + Width'(ex_cnt);
      if (branch_valid_i && mispredict_i) begin
        cnt_d[commit_pkg::PERF_MISPREDICT] = cnt_q[commit_pkg::PERF_MISPREDICT] + 1'b1;
      end
      if (halt_i) begin
        cnt_d[commit_pkg::PERF_FENCE_STALL] = cnt_q[commit_pkg::PERF_FENCE_STALL] + 1'b1;
      end
    end
    if (perf_we_i && addr_ok) begin
      cnt_d[perf_addr_i] = perf_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < commit_pkg::NR_PERF_CNT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // unmapped slots read as zero
  assign perf_rdata_o = addr_ok ? cnt_q[perf_addr_i] : '0;

endmodule

`default_nettype wire

// File: trace/trace_fifo.sv
// retired-pc trace queue
// fixed-depth circular buffer with a sticky flag for dropped pushes

`timescale 1ns/100ps
`default_nettype none

module trace_fifo #(
  parameter int unsigned DataWidth = 39,
  parameter int unsigned Depth     = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  logic [DataWidth-1:0] data_i,
  input  logic                 pop_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 empty_o,
  output logic                 overflow_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  logic [DataWidth-1:0] mem_q [Depth];
  logic [PtrW-1:0]      wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]      count_q;
  logic                 full, push_ok, pop_ok;
  logic                 overflow_q;

  assign full    = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign pop_ok  = pop_i && !empty_o;
  // a pop in the same cycle frees the slot
  assign push_ok = push_i && (!full || pop_ok);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
      // dropped push, held until reset
      if (push_i && !push_ok) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o     = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

`default_nettype wire

// File: trace/rr_arbiter.sv
// round-robin arbiter for the trace queues
// grants one requester per cycle and registers the winning payload

`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NumIn     = 2,
  parameter int unsigned DataWidth = 39
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [NumIn-1:0]                req_i,
  input  logic [NumIn-1:0][DataWidth-1:0] data_i,
  output logic [NumIn-1:0]                gnt_o,
  output logic                            valid_o,
  output logic [DataWidth-1:0]            data_o
);

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxW-1:0]      last_q, win_idx;
  logic                 found;
  logic                 valid_q;
  logic [DataWidth-1:0] data_q;

  // search starts one past the last winner
  always_comb begin
    int unsigned cand;
    found   = 1'b0;
    win_idx = last_q;
    gnt_o   = '0;
    for (int unsigned i = 1; i <= NumIn; i++) begin
      cand = (int'(last_q) + i) % NumIn;
      if (!found && req_i[cand]) begin
        found   = 1'b1;
        win_idx = IdxW'(cand);
      end
    end
    if (found) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= found;
      if (found) begin
        last_q <= win_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (found) begin
      data_q <= data_i[win_idx];
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// File: src/commit_monitor.sv
// commit monitor top level
// joins the flush controller, the counter bank and the merged
// retired-pc trace of both commit ports

`timescale 1ns/100ps
`default_nettype none

module commit_monitor #(
  parameter int unsigned TraceDepth = commit_pkg::TRACE_DEPTH
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                 commit_ack_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0][commit_pkg::VLEN-1:0] commit_pc_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                 commit_ex_valid_i,
  input  logic                                                   eret_i,
  input  logic                                                   fence_i_i,
  input  logic                                                   fence_i,
  input  logic                                                   branch_valid_i,
  input  logic                                                   mispredict_i,
  input  logic                                                   debug_mode_i,
  input  logic                                                   flush_l1_i,
  input  logic                                                   dcache_flush_ack_i,
  input  logic [commit_pkg::PERF_ADDR_WIDTH-1:0]                 perf_addr_i,
  input  logic                                                   perf_we_i,
  input  logic [commit_pkg::PERF_CNT_WIDTH-1:0]                  perf_wdata_i,
  output logic                                                   flush_pipeline_o,
  output logic                                                   set_pc_o,
  output logic                                                   flush_icache_o,
  output logic                                                   dcache_flush_o,
  output logic                                                   halt_o,
  output logic                                                   flush_done_o,
  output logic [commit_pkg::PERF_CNT_WIDTH-1:0]                  perf_rdata_o,
  output logic                                                   trace_valid_o,
  output logic [commit_pkg::VLEN-1:0]                            trace_pc_o,
  output logic                                                   trace_overflow_o
);

  localparam int unsigned NrPorts = commit_pkg::NR_COMMIT_PORTS;

  logic [NrPorts-1:0]                       retire;
  logic                                     ex_valid;
  logic                                     flush_dcache;
  logic [NrPorts-1:0][commit_pkg::VLEN-1:0] fifo_data;
  logic [NrPorts-1:0]                       fifo_empty, fifo_pop, fifo_overflow;

  // retire without exception pushes a trace entry
  assign retire   = commit_ack_i & ~commit_ex_valid_i;
  assign ex_valid = |(commit_ack_i & commit_ex_valid_i);

  // ------------------------------------------------
  // flush control
  // ------------------------------------------------
  commit_ctrl i_commit_ctrl (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .ex_valid_i         ( ex_valid           ),
    .eret_i             ( eret_i             ),
    .fence_i_i          ( fence_i_i          ),
    .fence_i            ( fence_i            ),
    .dcache_flush_ack_i ( dcache_flush_ack_i ),
    .flush_pipeline_o   ( flush_pipeline_o   ),
    .set_pc_o           ( set_pc_o           ),
    .flush_icache_o     ( flush_icache_o     ),
    .flush_dcache_o     ( flush_dcache       ),
    .halt_o             ( halt_o             )
  );

  // l1 flush from outside shares the cache acknowledge
  assign dcache_flush_o = flush_dcache | flush_l1_i;
  assign flush_done_o   = dcache_flush_ack_i;

  perf_counters #(
    .Width ( commit_pkg::PERF_CNT_WIDTH )
  ) i_perf_counters (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .debug_mode_i      ( debug_mode_i      ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .branch_valid_i    ( branch_valid_i    ),
    .mispredict_i      ( mispredict_i      ),
    .halt_i            ( halt_o            ),
    .perf_addr_i       ( perf_addr_i       ),
    .perf_we_i         ( perf_we_i         ),
    .perf_wdata_i      ( perf_wdata_i      ),
    .perf_rdata_o      ( perf_rdata_o      )
  );

  // ------------------------------------------------
  // retired-pc trace
  // ------------------------------------------------
  for (genvar i = 0; i < NrPorts; i++) begin : gen_trace_fifo
    trace_fifo #(
      .DataWidth ( commit_pkg::VLEN ),
      .Depth     ( TraceDepth       )
    ) i_trace_fifo (
      .clk_i      ( clk_i            ),
      .rst_ni     ( rst_ni           ),
      .push_i     ( retire[i]        ),
      .data_i     ( commit_pc_i[i]   ),
      .pop_i      ( fifo_pop[i]      ),
      .data_o     ( fifo_data[i]     ),
      .empty_o    ( fifo_empty[i]    ),
      .overflow_o ( fifo_overflow[i] )
    );
  end

  rr_arbiter #(
    .NumIn     ( NrPorts          ),
    .DataWidth ( commit_pkg::VLEN )
  ) i_rr_arbiter (
    .clk_i   ( clk_i         ),
    .rst_ni  ( rst_ni        ),
    .req_i   ( ~fifo_empty   ),
    .data_i  ( fifo_data     ),
    .gnt_o   ( fifo_pop      ),
    .valid_o ( trace_valid_o ),
    .data_o  ( trace_pc_o    )
  );

  assign trace_overflow_o = |fifo_overflow;

endmodule

`default_nettype wire

// File: test/commit_monitor_assert.sv
// commit flush controller checks
// concurrent properties on the flush pulses and the fence wait,
// attached to every commit_ctrl instance

`timescale 1ns/100ps
`default_nettype none

module commit_monitor_assert (
  input logic                    clk_i,
  input logic                    rst_ni,
  input commit_pkg::ctrl_state_t state_i,
  input logic                    dcache_flush_ack_i,
  input logic                    flush_pipeline_i,
  input logic                    set_pc_i,
  input logic                    flush_icache_i,
  input logic                    flush_dcache_i,
  input logic                    halt_i
);

  halt_matches_dcache_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    halt_i == flush_dcache_i)
    else $error("halt and dcache flush request differ");

  set_pc_matches_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    set_pc_i == flush_pipeline_i)
    else $error("set_pc and pipeline flush differ");

  icache_flush_with_pipeline: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_icache_i |-> flush_pipeline_i)
    else $error("icache flush without a pipeline flush");

  // the wait only ends through the cache acknowledge
  dcache_release_after_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(flush_dcache_i) |->
      $past(state_i == commit_pkg::CTRL_WAIT_FLUSH && dcache_flush_ack_i))
    else $error("dcache flush dropped without an acknowledge");

endmodule

`default_nettype wire

// File: test/tb_commit_monitor.sv
// commit monitor testbench
// directed tests for flush sequencing, the counter bank and the trace path

`timescale 1ns/100ps
`default_nettype none

module tb_commit_monitor;

  localparam int unsigned NrPorts = commit_pkg::NR_COMMIT_PORTS;
  localparam int unsigned PcW     = commit_pkg::VLEN;
  localparam int unsigned CntW    = commit_pkg::PERF_CNT_WIDTH;
  localparam int unsigned NrCnt   = commit_pkg::NR_PERF_CNT;
  localparam int          Timeout = 50;

  logic                             clk_i, rst_ni;
  logic [NrPorts-1:0]               commit_ack_i, commit_ex_valid_i;
  logic [NrPorts-1:0][PcW-1:0]      commit_pc_i;
  logic                             eret_i, fence_i_i, fence_i;
  logic                             branch_valid_i, mispredict_i, debug_mode_i;
  logic                             flush_l1_i, dcache_flush_ack_i;
  logic [commit_pkg::PERF_ADDR_WIDTH-1:0] perf_addr_i;
  logic                             perf_we_i;
  logic [CntW-1:0]                  perf_wdata_i, perf_rdata_o;
  logic                             flush_pipeline_o, set_pc_o, flush_icache_o;
  logic                             dcache_flush_o, halt_o, flush_done_o;
  logic                             trace_valid_o, trace_overflow_o;
  logic [PcW-1:0]                   trace_pc_o;

  int              errors, tests_run, tests_failed;
  logic [CntW-1:0] model [NrCnt];
  logic [PcW-1:0]  exp_q0 [$];
  logic [PcW-1:0]  exp_q1 [$];

  commit_monitor #(
    .TraceDepth ( commit_pkg::TRACE_DEPTH )
  ) DUT (
    .clk_i, .rst_ni, .commit_ack_i, .commit_pc_i, .commit_ex_valid_i,
    .eret_i, .fence_i_i, .fence_i, .branch_valid_i, .mispredict_i,
    .debug_mode_i, .flush_l1_i, .dcache_flush_ack_i, .perf_addr_i,
    .perf_we_i, .perf_wdata_i, .flush_pipeline_o, .set_pc_o,
    .flush_icache_o, .dcache_flush_o, .halt_o, .flush_done_o,
    .perf_rdata_o, .trace_valid_o, .trace_pc_o, .trace_overflow_o
  );

  bind commit_ctrl commit_monitor_assert i_ctrl_assert (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .state_i            ( state_q            ),
    .dcache_flush_ack_i ( dcache_flush_ack_i ),
    .flush_pipeline_i   ( flush_pipeline_o   ),
    .set_pc_i           ( set_pc_o           ),
    .flush_icache_i     ( flush_icache_o     ),
    .flush_dcache_i     ( flush_dcache_o     ),
    .halt_i             ( halt_o             )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("ERROR %s", what);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic clear_inputs();
    commit_ack_i       <= '0;
    commit_ex_valid_i  <= '0;
    eret_i             <= 1'b0;
    fence_i_i          <= 1'b0;
    fence_i            <= 1'b0;
    branch_valid_i     <= 1'b0;
    mispredict_i       <= 1'b0;
    flush_l1_i         <= 1'b0;
    dcache_flush_ack_i <= 1'b0;
    perf_we_i          <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni       <= 1'b0;
    debug_mode_i <= 1'b0;
    clear_inputs();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  task automatic write_counter(input logic [2:0] addr, input logic [CntW-1:0] data);
    @(posedge clk_i);
    perf_addr_i  <= addr;
    perf_we_i    <= 1'b1;
    perf_wdata_i <= data;
    @(posedge clk_i);
    perf_we_i <= 1'b0;
  endtask

  task automatic read_check(input logic [2:0] addr, input logic [CntW-1:0] exp);
    @(posedge clk_i);
    perf_addr_i <= addr;
    @(negedge clk_i);
    check_val($sformatf("perf_rdata_o[%0d]", addr), perf_rdata_o, exp);
  endtask

  // match one trace beat against the head of either port's queue
  task automatic collect_trace();
    if (trace_valid_o) begin
      if (exp_q0.size() != 0 && trace_pc_o == exp_q0[0]) begin
        void'(exp_q0.pop_front());
      end else if (exp_q1.size() != 0 && trace_pc_o == exp_q1[0]) begin
        void'(exp_q1.pop_front());
      end else begin
        check_val("trace_pc_o", trace_pc_o, exp_q0.size() != 0 ? exp_q0[0] : '0);
      end
    end
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_flush_pulses();
    int err_start;
    err_start = errors;
    // 0 exception, 1 eret, 2 fence.i
    for (int kind = 0; kind < 3; kind++) begin
      @(posedge clk_i);
      case (kind)
        0: begin
          commit_ack_i      <= 2'b01;
          commit_ex_valid_i <= 2'b01;
        end
        1: eret_i <= 1'b1;
        default: fence_i_i <= 1'b1;
      endcase
      @(negedge clk_i);
      check_val("flush_pipeline_o", flush_pipeline_o, 1'b0);
      @(posedge clk_i);
      clear_inputs();
      @(negedge clk_i);
      check_val("flush_pipeline_o", flush_pipeline_o, 1'b1);
      check_val("set_pc_o", set_pc_o, 1'b1);
      check_val("flush_icache_o", flush_icache_o, kind == 2);
      @(negedge clk_i);
      check_val("flush_pipeline_o", flush_pipeline_o, 1'b0);
      check_val("set_pc_o", set_pc_o, 1'b0);
      check_val("flush_icache_o", flush_icache_o, 1'b0);
    end
    report_test("flush pulses", err_start);
  endtask

  task automatic test_fence_wait();
    int err_start;
    int delay;
    int n;
    err_start = errors;
    @(posedge clk_i);
    fence_i <= 1'b1;
    @(posedge clk_i);
    fence_i <= 1'b0;
    @(negedge clk_i);
    n = 0;
    while (!halt_o && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    check_true(halt_o, "halt_o never rose after the fence");
    delay = 2 + int'($urandom % 6);
    repeat (delay) begin
      check_val("dcache_flush_o", dcache_flush_o, 1'b1);
      check_val("halt_o", halt_o, 1'b1);
      check_val("flush_pipeline_o", flush_pipeline_o, 1'b0);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    dcache_flush_ack_i <= 1'b1;
    @(negedge clk_i);
    check_val("flush_done_o", flush_done_o, 1'b1);
    check_val("dcache_flush_o", dcache_flush_o, 1'b1);
    @(posedge clk_i);
    dcache_flush_ack_i <= 1'b0;
    @(negedge clk_i);
    check_val("dcache_flush_o", dcache_flush_o, 1'b0);
    check_val("halt_o", halt_o, 1'b0);
    check_val("flush_pipeline_o", flush_pipeline_o, 1'b1);
    check_val("set_pc_o", set_pc_o, 1'b1);
    @(negedge clk_i);
    check_val("flush_pipeline_o", flush_pipeline_o, 1'b0);
    // external l1 flush, no halt
    @(posedge clk_i);
    flush_l1_i <= 1'b1;
    @(negedge clk_i);
    check_val("dcache_flush_o", dcache_flush_o, 1'b1);
    check_val("halt_o", halt_o, 1'b0);
    check_val("flush_done_o", flush_done_o, 1'b0);
    @(posedge clk_i);
    dcache_flush_ack_i <= 1'b1;
    @(negedge clk_i);
    check_val("flush_done_o", flush_done_o, 1'b1);
    @(posedge clk_i);
    clear_inputs();
    @(negedge clk_i);
    check_val("dcache_flush_o", dcache_flush_o, 1'b0);
    check_val("flush_done_o", flush_done_o, 1'b0);
    report_test("fence wait", err_start);
  endtask

  task automatic test_counters();
    int err_start;
    logic [NrPorts-1:0] ack, ex;
    logic halted;
    err_start = errors;
    halted    = 1'b0;
    // freeze, then clear every slot
    @(posedge clk_i);
    clear_inputs();
    debug_mode_i <= 1'b1;
    for (int i = 0; i < NrCnt; i++) begin
      write_counter(3'(i), '0);
      model[i] = '0;
    end
    for (int k = 0; k < 16; k++) begin
      ack = NrPorts'(k % 4);
      ex  = (k % 3 == 0) ? 2'b10 : 2'b00;
      @(posedge clk_i);
      debug_mode_i       <= 1'b0;
      commit_ack_i       <= ack;
      commit_ex_valid_i  <= ex;
      branch_valid_i     <= k[0];
      mispredict_i       <= (k % 4 == 1) || (k % 4 == 2);
      fence_i            <= (k == 3);
      dcache_flush_ack_i <= (k == 9);
      // software write colliding with a retirement
      perf_we_i          <= (k == 13);
      perf_addr_i        <= commit_pkg::PERF_INSTRET;
      perf_wdata_i       <= 64'h100;
      @(negedge clk_i);
      model[commit_pkg::PERF_CYCLE]     += 1;
      model[commit_pkg::PERF_INSTRET]   += $countones(ack & ~ex);
      model[commit_pkg::PERF_EXCEPTION] += $countones(ack & ex);
      if (k[0] && (k % 4 == 1)) begin
        model[commit_pkg::PERF_MISPREDICT] += 1;
      end
      if (halted) begin
        model[commit_pkg::PERF_FENCE_STALL] += 1;
      end
      // halt rises the cycle after the fence and falls the cycle after the ack
      if (k == 3) begin
        halted = 1'b1;
      end else if (k == 9) begin
        halted = 1'b0;
      end
      if (k == 13) begin
        model[commit_pkg::PERF_INSTRET] = 64'h100;
      end
    end
    @(posedge clk_i);
    clear_inputs();
    debug_mode_i <= 1'b1;
    for (int i = 0; i < NrCnt; i++) begin
      read_check(3'(i), model[i]);
    end
    read_check(3'd5, '0);
    report_test("counters", err_start);
  endtask

  task automatic test_debug_freeze();
    int err_start;
    err_start = errors;
    for (int k = 0; k < 8; k++) begin
      @(posedge clk_i);
      commit_ack_i       <= 2'b11;
      commit_ex_valid_i  <= NrPorts'(k % 2);
      branch_valid_i     <= 1'b1;
      mispredict_i       <= 1'b1;
      fence_i            <= (k == 1);
      dcache_flush_ack_i <= (k == 5);
    end
    @(posedge clk_i);
    clear_inputs();
    for (int i = 0; i < NrCnt; i++) begin
      read_check(3'(i), model[i]);
    end
    report_test("debug freeze", err_start);
  endtask

  task automatic test_trace_order();
    int err_start;
    int n;
    logic [NrPorts-1:0] ack;
    logic [PcW-1:0] pc0, pc1;
    err_start = errors;
    apply_reset();
    exp_q0.delete();
    exp_q1.delete();
    for (int k = 0; k < 24; k++) begin
      ack = (k % 2 == 0) ? NrPorts'($urandom) : '0;
      pc0 = PcW'({$urandom, $urandom});
      pc1 = PcW'({$urandom, $urandom});
      @(posedge clk_i);
      commit_ack_i      <= ack;
      commit_ex_valid_i <= '0;
      commit_pc_i[0]    <= pc0;
      commit_pc_i[1]    <= pc1;
      if (ack[0]) exp_q0.push_back(pc0);
      if (ack[1]) exp_q1.push_back(pc1);
      @(negedge clk_i);
      collect_trace();
    end
    @(posedge clk_i);
    clear_inputs();
    n = 0;
    while ((exp_q0.size() + exp_q1.size()) != 0 && n < Timeout) begin
      @(negedge clk_i);
      collect_trace();
      n++;
    end
    check_true((exp_q0.size() + exp_q1.size()) == 0, "retired PCs missing from the trace");
    repeat (3) begin
      @(negedge clk_i);
      check_val("trace_valid_o", trace_valid_o, 1'b0);
    end
    check_val("trace_overflow_o", trace_overflow_o, 1'b0);
    report_test("trace ordering", err_start);
  endtask

  task automatic test_trace_overflow();
    int err_start;
    err_start = errors;
    // two pushes per cycle against one pop
    repeat (2 * commit_pkg::TRACE_DEPTH + 2) begin
      @(posedge clk_i);
      commit_ack_i      <= '1;
      commit_ex_valid_i <= '0;
      commit_pc_i[0]    <= PcW'({$urandom, $urandom});
      commit_pc_i[1]    <= PcW'({$urandom, $urandom});
    end
    @(posedge clk_i);
    clear_inputs();
    repeat (12) begin
      @(negedge clk_i);
      check_val("trace_overflow_o", trace_overflow_o, 1'b1);
    end
    report_test("trace overflow", err_start);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(79));
    errors             = 0;
    tests_run          = 0;
    tests_failed       = 0;
    rst_ni             = 1'b0;
    commit_ack_i       = '0;
    commit_ex_valid_i  = '0;
    commit_pc_i        = '0;
    eret_i             = 1'b0;
    fence_i_i          = 1'b0;
    fence_i            = 1'b0;
    branch_valid_i     = 1'b0;
    mispredict_i       = 1'b0;
    debug_mode_i       = 1'b0;
    flush_l1_i         = 1'b0;
    dcache_flush_ack_i = 1'b0;
    perf_addr_i        = '0;
    perf_we_i          = 1'b0;
    perf_wdata_i       = '0;
    apply_reset();
    test_flush_pulses();
    test_fence_wait();
    test_counters();
    test_debug_freeze();
    test_trace_order();
    test_trace_overflow();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
common/commit_pkg.sv
src/commit_ctrl.sv
src/perf_counters.sv
trace/trace_fifo.sv
trace/rr_arbiter.sv
src/commit_monitor.sv
test/commit_monitor_assert.sv
test/tb_commit_monitor.sv

// File: Makefile
TOP = tb_commit_monitor

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)
	out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir
